// ==== verilog/sobelPkg.sv ====
package sobelPkg;

    // line geometry.
    localparam int LineWidth = 64;      // pixels per camera line.
    localparam int WordBits = 32;       // edge bits per packed output word.
    localparam int NumLineDelays = 2;   // one per row above the current pixel.

    // raw camera pixel, 8-bit grey.
    typedef logic [7:0] pixelT;

    // column index inside a line.
    typedef logic [$clog2(LineWidth)-1:0] columnT;

    // signed gradient, weights 1 2 1 give at most +-1020.
    typedef logic signed [10:0] gradT;

    // |gx| + |gy|, at most 2040.
    typedef logic [11:0] magT;

    // edge threshold, compared unsigned against the magnitude.
    typedef logic [15:0] thresholdT;

    // packed edge bits, first bit of a group in the msb.
    typedef logic [WordBits-1:0] edgeWordT;

endpackage

// ==== verilog/rasterBus.sv ====
`timescale 1ns/100ps

// pixel stream plus its raster position, driven by the tracker.
interface rasterBus
    import sobelPkg::*;
();

    pixelT  pixel;        // registered camera pixel.
    logic   pixelValid;   // one cycle per accepted pixel.
    columnT column;       // column of that pixel.
    logic   windowReady;  // row >= 2 and column >= 2, so the 3x3 window is complete.

    modport source (
        output pixel,
        output pixelValid,
        output column,
        output windowReady
    );

    // line delays only need the strobe and the address.
    modport tap (
        input pixelValid,
        input column
    );

    modport sink (
        input pixel,
        input pixelValid,
        input column,
        input windowReady
    );

endinterface

// ==== verilog/rasterTracker.sv ====
`timescale 1ns/100ps

module rasterTracker
    import sobelPkg::*;
(
    input  logic      camClock,
    input  logic      rstN,
    input  pixelT     camData,
    input  logic      pixelValid,
    input  logic      hsync,
    input  logic      vsync,
    rasterBus.source  bus
);

    columnT     nextColumn;   // column the next pixel will get.
    logic [1:0] rowCount;     // saturates at 2, only the border matters.

    // control part, strobe and raster counters.
    always_ff @(posedge camClock) begin
        if (!rstN) begin
            bus.pixelValid <= 1'b0;
            bus.windowReady <= 1'b0;
            nextColumn <= '0;
            rowCount <= '0;
        end else begin
            bus.pixelValid <= pixelValid;   // bus is one cycle behind the input.
            if (vsync) begin
                nextColumn <= '0;           // new frame, back to the top left.
                rowCount <= '0;
            end else if (hsync) begin
                nextColumn <= '0;
                if (rowCount != 2'd2) begin
                    rowCount <= rowCount + 2'd1;
                end
            end else if (pixelValid) begin
                nextColumn <= nextColumn + 1'b1;   // wraps at LineWidth.
            end
            // border test done once here, downstream only sees the flag.
            if (pixelValid) begin
                bus.windowReady <= (rowCount == 2'd2) && (nextColumn >= columnT'(2));
            end
        end
    end

    // payload part.
    always_ff @(posedge camClock) begin
        if (pixelValid) begin
            bus.pixel <= camData;
            bus.column <= nextColumn;
        end
    end

endmodule

// ==== verilog/lineDelay.sv ====
`timescale 1ns/100ps

module lineDelay
    import sobelPkg::*;
#(
    // 1 when tapIn is the registered output of an earlier delay,
    // so it belongs to the previous pixel's column.
    parameter int TapInLag = 0
)
(
    input  logic    camClock,
    rasterBus.tap   bus,
    input  pixelT   tapIn,
    output pixelT   tapOut
);

    pixelT  lineMem [LineWidth];   // one full line, addressed by column.
    columnT lastColumn;            // column of the previous accepted pixel.
    columnT writeColumn;

    // a lagged input is written back where it was read one pixel earlier.
    assign writeColumn = (TapInLag != 0) ? lastColumn : bus.column;

    always_ff @(posedge camClock) begin
        if (bus.pixelValid) begin
            tapOut <= lineMem[bus.column];     // pixel from one line earlier.
            lineMem[writeColumn] <= tapIn;     // replace it with this line's pixel.
            lastColumn <= bus.column;
        end
    end

endmodule

// ==== verilog/sobelKernel.sv ====
`timescale 1ns/100ps

module sobelKernel
    import sobelPkg::*;
(
    input  logic       camClock,
    input  logic       rstN,
    rasterBus.sink     bus,
    input  pixelT      rowAbove,      // row r-1, valid one cycle after the bus pixel.
    input  pixelT      rowTwoAbove,   // row r-2, same timing.
    input  thresholdT  threshold,
    output logic       edgeBit,
    output logic       edgeValid
);

    // 1 2 1 weighted sum of three pixels, at most 1020.
    function automatic logic [9:0] weightSum(pixelT a, pixelT b, pixelT c);
        return 10'(a) + {1'b0, b, 1'b0} + 10'(c);
    endfunction

    function automatic magT absGrad(gradT g);
        return magT'((g < 0) ? -g : g);
    endfunction

    pixelT      bottomRow [3];   // row r, columns c, c-1, c-2.
    pixelT      midRow [2];      // row r-1, columns c-1, c-2, column c is the live tap.
    pixelT      topRow [2];      // row r-2, same layout.
    logic       valid1, ready1;
    logic [9:0] leftSum, rightSum, upperSum, lowerSum;
    gradT       gx, gy;
    logic       valid2, ready2;

    // stage 1, window shift. the taps still hold the previous pixel's rows here.
    always_ff @(posedge camClock) begin
        if (bus.pixelValid) begin
            bottomRow[0] <= bus.pixel;
            bottomRow[1] <= bottomRow[0];
            bottomRow[2] <= bottomRow[1];
            midRow[0] <= rowAbove;
            midRow[1] <= midRow[0];
            topRow[0] <= rowTwoAbove;
            topRow[1] <= topRow[0];
            ready1 <= bus.windowReady;
        end
    end

    // column and row sums over the window, right column straight from the taps.
    assign leftSum = weightSum(topRow[1], midRow[1], bottomRow[2]);
    assign rightSum = weightSum(rowTwoAbove, rowAbove, bottomRow[0]);
    assign upperSum = weightSum(topRow[1], topRow[0], rowTwoAbove);
    assign lowerSum = weightSum(bottomRow[2], bottomRow[1], bottomRow[0]);

    // stage 2, gradients.
    always_ff @(posedge camClock) begin
        gx <= gradT'({1'b0, rightSum}) - gradT'({1'b0, leftSum});
        gy <= gradT'({1'b0, lowerSum}) - gradT'({1'b0, upperSum});
        ready2 <= ready1;
    end

    // stage 3, magnitude and compare. border pixels give a 0 bit.
    always_ff @(posedge camClock) begin
        edgeBit <= ready2 && ((absGrad(gx) + absGrad(gy)) > threshold);
    end

    // valid pipeline, the only state that needs reset.
    always_ff @(posedge camClock) begin
        if (!rstN) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            edgeValid <= 1'b0;
        end else begin
            valid1 <= bus.pixelValid;
            valid2 <= valid1;
            edgeValid <= valid2;   // 3 cycles after the bus strobe.
        end
    end

endmodule

// ==== verilog/edgePacker.sv ====
`timescale 1ns/100ps

module edgePacker
    import sobelPkg::*;
(
    input  logic      camClock,
    input  logic      rstN,
    input  logic      hsync,
    input  logic      edgeBit,
    input  logic      edgeValid,
    output edgeWordT  edgeWord,
    output logic      wordValid
);

    edgeWordT                      shiftReg;   // newest bit in the lsb.
    logic [$clog2(WordBits)-1:0]   bitCount;   // bits taken so far in this word.

    // full word sits in the shift register during the strobe cycle.
    assign edgeWord = shiftReg;

    always_ff @(posedge camClock) begin
        if (edgeValid) begin
            shiftReg <= {shiftReg[WordBits-2:0], edgeBit};
        end
    end

    always_ff @(posedge camClock) begin
        if (!rstN) begin
            bitCount <= '0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= edgeValid && (bitCount == WordBits - 1);   // 32nd bit.
            if (hsync) begin
                bitCount <= '0;              // words never span two lines.
            end else if (edgeValid) begin
                bitCount <= bitCount + 1'b1; // wraps back to 0 after a full word.
            end
        end
    end

endmodule

// ==== verilog/sobelEdgeTop.sv ====
`timescale 1ns/100ps

module sobelEdgeTop
    import sobelPkg::*;
(
    input  logic       camClock,
    input  logic       rstN,
    input  pixelT      camData,
    input  logic       pixelValid,
    input  logic       hsync,
    input  logic       vsync,
    input  thresholdT  threshold,
    output edgeWordT   edgeWord,
    output logic       wordValid
);

    rasterBus rasterIf ();

    pixelT tapChain [NumLineDelays+1];   // [0] is the current row, [i] is i rows up.
    logic  edgeBit;
    logic  edgeValid;

    rasterTracker tracker0 (
        .camClock   (camClock),
        .rstN       (rstN),
        .camData    (camData),
        .pixelValid (pixelValid),
        .hsync      (hsync),
        .vsync      (vsync),
        .bus        (rasterIf.source)
    );

    assign tapChain[0] = rasterIf.pixel;

    // chained line delays, each one builds the next row up.
    for (genvar i = 0; i < NumLineDelays; i++) begin : genDelay
        lineDelay #(
            .TapInLag ((i == 0) ? 0 : 1)   // later delays see a registered tap.
        ) delay (
            .camClock (camClock),
            .bus      (rasterIf.tap),
            .tapIn    (tapChain[i]),
            .tapOut   (tapChain[i+1])
        );
    end

    sobelKernel kernel0 (
        .camClock    (camClock),
        .rstN        (rstN),
        .bus         (rasterIf.sink),
        .rowAbove    (tapChain[1]),
        .rowTwoAbove (tapChain[2]),
        .threshold   (threshold),
        .edgeBit     (edgeBit),
        .edgeValid   (edgeValid)
    );

    edgePacker packer0 (
        .camClock  (camClock),
        .rstN      (rstN),
        .hsync     (hsync),
        .edgeBit   (edgeBit),
        .edgeValid (edgeValid),
        .edgeWord  (edgeWord),
        .wordValid (wordValid)
    );

endmodule

// ==== testbench/sobelEdge_chk.sv ====
`timescale 1ns/100ps

// protocol checks on the top-level ports.
module sobelEdgeChk (
    input logic camClock,
    input logic rstN,
    input logic pixelValid,
    input logic hsync,
    input logic vsync,
    input logic wordValid
);

    int assertFails = 0;   // failed assertions so far.

    resetQuiet: assert property (@(posedge camClock) !rstN |=> !wordValid)
        else begin
            assertFails++;
            $error("wordValid high after a reset cycle");
        end

    // a word takes 32 pixels, so strobes are never adjacent.
    singleStrobe: assert property (@(posedge camClock) disable iff (!rstN)
                                   wordValid |=> !wordValid)
        else begin
            assertFails++;
            $error("wordValid high on two consecutive cycles");
        end

    syncIdle: assert property (@(posedge camClock) disable iff (!rstN)
                               (hsync || vsync) |-> !pixelValid)
        else begin
            assertFails++;
            $error("sync pulse on a pixel cycle");
        end

endmodule

bind sobelEdgeTop sobelEdgeChk chk0 (
    .camClock   (camClock),
    .rstN       (rstN),
    .pixelValid (pixelValid),
    .hsync      (hsync),
    .vsync      (vsync),
    .wordValid  (wordValid)
);

// ==== testbench/sobelEdgeTb.sv ====
`timescale 1ns/100ps

module sobelEdgeTb
    import sobelPkg::*;
();

    localparam int FrameRows = 5;                 // rows per test frame.
    localparam int NumFrames = 7;
    localparam int FlatFrame = 0;
    localparam int StripeFrame = 1;
    localparam int RandomFrame = 2;
    localparam int MaxLineCycles = LineWidth * 4 + 6 + 1 + 8;    // pixels, gaps, hsync, idle.
    localparam int MaxFrameCycles = FrameRows * MaxLineCycles + 10;
    localparam int TimeoutCycles = 2 * (16 + 40 + NumFrames * MaxFrameCycles);

    logic      camClock;
    logic      rstN;
    pixelT     camData;
    logic      pixelValid, hsync, vsync;
    thresholdT threshold;
    edgeWordT  edgeWord;
    logic      wordValid;

    logic [31:0] lfsrState = 32'd76613;
    pixelT       frame [FrameRows][LineWidth];   // current frame in row major order.
    edgeWordT    expQ [$];                       // words the model expects in order.
    int          wordCount = 0;
    int          cycleCount = 0;

    sobelEdgeTop dut0 (.*);

    initial begin
        camClock = 1'b0;
        forever #4 camClock = ~camClock;   // 8 ns period.
    end

    // galois form with taps 32 22 2 1.
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] nextBits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);   // one step per bit.
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic int px(int r, int c);
        return int'(frame[r][c]);
    endfunction

    // sobel edge bit for the window whose bottom-right corner is (r, c).
    function automatic logic edgeModel(int r, int c, thresholdT thr);
        int gx, gy;
        if (r < 2 || c < 2) return 1'b0;                       // border.
        gx = (px(r-2, c) + 2 * px(r-1, c) + px(r, c))
           - (px(r-2, c-2) + 2 * px(r-1, c-2) + px(r, c-2));
        gy = (px(r, c-2) + 2 * px(r, c-1) + px(r, c))
           - (px(r-2, c-2) + 2 * px(r-2, c-1) + px(r-2, c));
        if (gx < 0) gx = -gx;
        if (gy < 0) gy = -gy;
        return (gx + gy) > int'(thr);
    endfunction

    task automatic reportFailure(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compareWord(edgeWordT got, edgeWordT exp, int index);
        if (got !== exp)
            reportFailure($sformatf("error at %0d ns: word %0d is %h, expected %h",
                                    $time, index, got, exp));
    endtask

    task automatic compareCount(int got, int exp);
        if (got != exp)
            reportFailure($sformatf("error at %0d ns: %0d words seen, expected %0d",
                                    $time, got, exp));
    endtask

    task automatic driveIdle(int cycles);
        repeat (cycles) begin
            @(posedge camClock);
            pixelValid <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end
    endtask

    task automatic drivePixel(pixelT p);
        @(posedge camClock);
        camData <= p;
        pixelValid <= 1'b1;
        hsync <= 1'b0;
        vsync <= 1'b0;
    endtask

    task automatic pulseSync(logic h, logic v);
        @(posedge camClock);
        pixelValid <= 1'b0;
        hsync <= h;
        vsync <= v;
    endtask

    // fill the frame, queue the model's words, then stream the frame out.
    task automatic sendFrame(int kind, thresholdT thr);
        pixelT      level;
        edgeWordT   word;
        logic [1:0] g;
        level = pixelT'(nextBits(8));   // flat frame grey level.
        for (int r = 0; r < FrameRows; r++) begin
            for (int c = 0; c < LineWidth; c++) begin
                case (kind)
                    FlatFrame:   frame[r][c] = level;
                    StripeFrame: frame[r][c] = ((c / 2) % 2 != 0) ? 8'hFF : 8'h00;   // 2 wide.
                    default:     frame[r][c] = pixelT'(nextBits(8));
                endcase
            end
        end
        for (int r = 0; r < FrameRows; r++) begin
            for (int w = 0; w < LineWidth / WordBits; w++) begin
                word = '0;
                for (int b = 0; b < WordBits; b++)
                    word = {word[WordBits-2:0], edgeModel(r, w * WordBits + b, thr)};
                expQ.push_back(word);   // first bit lands in the msb.
            end
        end
        @(posedge camClock);
        threshold <= thr;   // pipeline is empty here.
        for (int r = 0; r < FrameRows; r++) begin
            for (int c = 0; c < LineWidth; c++) begin
                g = 2'(nextBits(2));
                driveIdle(g[1] ? g[0] + 1 : 0);   // half the pixels get a random gap.
                drivePixel(frame[r][c]);
            end
            driveIdle(6);   // minimum gap before a sync.
            pulseSync(1'b1, 1'b0);
            driveIdle(nextBits(3) + 1);
        end
        pulseSync(1'b0, 1'b1);   // end of frame.
        driveIdle(4);
    endtask

    // words are stable between edges.
    always @(negedge camClock) begin
        if (rstN === 1'b1 && wordValid === 1'b1) begin
            if (expQ.size() == 0) begin
                reportFailure("a word was strobed while none was expected");
            end else begin
                wordCount++;
                compareWord(edgeWord, expQ.pop_front(), wordCount - 1);
            end
        end
    end

    // a failed bound assertion ends the run at once.
    always @(dut0.chk0.assertFails) begin
        if (dut0.chk0.assertFails != 0)
            reportFailure("a protocol assertion in the bound checker failed");
    end

    always @(posedge camClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles)
            reportFailure("the run did not finish within its cycle limit");
    end

    initial begin
        camData = '0;
        pixelValid = 1'b0;
        hsync = 1'b0;
        vsync = 1'b0;
        threshold = '0;
        rstN = 1'b0;
        repeat (16) @(posedge camClock);
        rstN <= 1'b1;
        driveIdle(20);                          // no pixels, so no words.
        sendFrame(FlatFrame, '0);               // all-zero words.
        sendFrame(StripeFrame, '0);             // interior all ones, strong last rows.
        sendFrame(RandomFrame, thresholdT'(nextBits(11)));   // border rows zero again.
        sendFrame(StripeFrame, 16'hFFFF);       // nothing passes.
        for (int f = 0; f < NumFrames - 4; f++)
            sendFrame(RandomFrame, thresholdT'(nextBits(11)));
        driveIdle(20);
        compareCount(wordCount, NumFrames * FrameRows * (LineWidth / WordBits));
        if (dut0.chk0.assertFails == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("%0d protocol assertions failed", dut0.chk0.assertFails);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

// ==== src.f ====
verilog/sobelPkg.sv
verilog/rasterBus.sv
verilog/rasterTracker.sv
verilog/lineDelay.sv
verilog/sobelKernel.sv
verilog/edgePacker.sv
verilog/sobelEdgeTop.sv
testbench/sobelEdge_chk.sv
testbench/sobelEdgeTb.sv

// ==== Bender.yml ====
package:
  name: sobel_edge

sources:
  - verilog/sobelPkg.sv
  - verilog/rasterBus.sv
  - verilog/rasterTracker.sv
  - verilog/lineDelay.sv
  - verilog/sobelKernel.sv
  - verilog/edgePacker.sv
  - verilog/sobelEdgeTop.sv
  - target: test
    files:
      - testbench/sobelEdge_chk.sv
      - testbench/sobelEdgeTb.sv
